/* src/chunk_builder.sv */
// chunk builder that groups per-cycle write counts into full and EOP chunk descriptors
`include "sched_consts.svh"

module chunk_builder (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [`SCHED_CNT_W-1:0] wr_num_valid,
        input  logic [`SCHED_CNT_W-1:0] wr_eop_position,
        input  logic                    fifo_full,
        output logic                    desc_push,
        output chunk_pkg::chunk_desc_t  desc,
        output logic                    wr_overflow
);

localparam int cnt_w = `SCHED_CNT_W;
localparam int chunk_w = `SCHED_CHUNK_W;
localparam int chunk_words = `SCHED_CHUNK_WORDS;

// words of the open chunk, always below 16
logic [cnt_w-1:0]       pending;
logic [cnt_w-1:0]       pending_nx;
logic [chunk_w-1:0]     fill_sum;
logic [chunk_w-1:0]     eop_sum;
logic                   has_eop;
logic                   push_nx;
chunk_pkg::chunk_desc_t desc_nx;

//////////////////////////////
// chunking rule
//////////////////////////////

always_comb begin
        has_eop  = |wr_eop_position;
        // open chunk plus everything that arrived this cycle
        fill_sum = chunk_w'(pending) + chunk_w'(wr_num_valid);
        // open chunk up to and including the EOP word
        eop_sum  = chunk_w'(pending) + chunk_w'(wr_eop_position);

        push_nx       = 1'b0;
        desc_nx.eop   = has_eop;
        desc_nx.count = eop_sum;
        pending_nx    = cnt_w'(fill_sum);

        if (has_eop) begin
                // EOP closes the chunk at 1 to 23 words
                push_nx    = 1'b1;
                // words after the EOP open the next packet
                pending_nx = wr_num_valid - wr_eop_position;
        end else if (fill_sum >= chunk_w'(chunk_words)) begin
                push_nx       = 1'b1;
                desc_nx.count = chunk_w'(chunk_words);
                // carry the spill into the next chunk
                pending_nx    = cnt_w'(fill_sum - chunk_w'(chunk_words));
        end
end

always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
                pending     <= '0;
                desc_push   <= 1'b0;
                wr_overflow <= 1'b0;
        end else begin
                pending   <= pending_nx;
                desc_push <= push_nx;
                // sticky, only reset clears it
                if (desc_push && fifo_full) begin
                        wr_overflow <= 1'b1;
                end
        end
end

// descriptor payload, only meaningful with desc_push
always_ff @(posedge clk) begin
        if (push_nx) begin
                desc <= desc_nx;
        end
end

endmodule

/* src/chunk_pkg.sv */
// chunk package with the descriptor type passed from the chunk builder to the tick scheduler
`include "sched_consts.svh"

package chunk_pkg;

        //////////////////////////////
        // chunk descriptor
        //////////////////////////////

        // one entry of the descriptor FIFO
        // eop set marks a chunk that closes a packet, count is then 1 to 23
        // eop clear marks a full chunk, count is then always 16
        typedef struct packed {
                logic                      eop;
                logic [`SCHED_CHUNK_W-1:0] count;
        } chunk_desc_t;

endpackage

/* src/sched_consts.svh */
// constants of the word-count read scheduler for lanes, chunk size, widths and FIFO depth
`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

// words moved per cycle on the write side and on the read side
`define SCHED_LANES 8

// words in one full, non-EOP chunk
`define SCHED_CHUNK_WORDS 16

// width of a per-cycle word count and of an EOP position
// holds 0 to 8
`define SCHED_CNT_W 4

// width of a chunk word count
// an EOP chunk carries up to 15 pending words plus 8 new ones
`define SCHED_CHUNK_W 5

// descriptor entries in the show-ahead FIFO
// small on purpose so that back-pressure reaches overflow quickly
`define SCHED_FIFO_DEPTH 16

`endif

/* src/show_ahead_fifo.sv */
// show-ahead FIFO that holds any payload type and presents its head entry without a read cycle
`include "sched_consts.svh"

module show_ahead_fifo #(
        parameter type payload_t = logic [7:0],
        parameter int  depth     = `SCHED_FIFO_DEPTH
) (
        input  logic     clk,
        input  logic     rst_n,
        input  logic     push,
        input  payload_t wdata,
        input  logic     pop,
        output payload_t rdata,
        output logic     full,
        output logic     empty
);

localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
localparam int used_w = $clog2(depth + 1);

// storage ring, payload only
payload_t mem [depth];

logic [ptr_w-1:0]  wr_ptr;
logic [ptr_w-1:0]  rd_ptr;
logic [used_w-1:0] used;
logic              do_push;
logic              do_pop;

// pointer step with wrap at the last entry
// works for depths that are not a power of two
function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
                return '0;
        end else begin
                return p + 1'b1;
        end
endfunction

assign full  = (used == used_w'(depth));
assign empty = (used == '0);

// a push into a full FIFO is lost here
assign do_push = push && !full;
assign do_pop  = pop && !empty;

// head entry straight from the array
assign rdata = mem[rd_ptr];

always_ff @(posedge clk) begin
        if (do_push) begin
                mem[wr_ptr] <= wdata;
        end
end

//////////////////////////////
// pointers and occupancy
//////////////////////////////

always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                used   <= '0;
        end else begin
                if (do_push) begin
                        wr_ptr <= ptr_inc(wr_ptr);
                end
                if (do_pop) begin
                        rd_ptr <= ptr_inc(rd_ptr);
                end
                // push and pop together leave the count alone
                case ({do_push, do_pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
                endcase
        end
end

endmodule

/* src/tick_pkg.sv */
// tick package with the state encoding of the read-side tick scheduler
package tick_pkg;

        //////////////////////////////
        // tick FSM states
        //////////////////////////////

        // a tick state names the tick currently shown on the read outputs
        // idle means nothing is playing
        // a chunk never needs more than three ticks
        typedef enum logic [1:0] {
                st_idle  = 2'b00,
                st_tick1 = 2'b01,
                st_tick2 = 2'b10,
                st_tick3 = 2'b11
        } tick_state_t;

endpackage

/* src/tick_scheduler.sv */
// tick scheduler that plays chunk descriptors out as read counts of at most eight words
`include "sched_consts.svh"

module tick_scheduler (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    rd_en,
        input  chunk_pkg::chunk_desc_t  head,
        input  logic                    fifo_empty,
        output logic                    pop,
        output logic [`SCHED_CNT_W-1:0] rd_num_valid,
        output logic                    rd_eop
);

localparam int cnt_w = `SCHED_CNT_W;
localparam int chunk_w = `SCHED_CHUNK_W;
localparam int lanes = `SCHED_LANES;

tick_pkg::tick_state_t state;
tick_pkg::tick_state_t state_nx;

// words of the playing chunk not yet put on the outputs
logic [chunk_w-1:0] left;
logic [chunk_w-1:0] left_nx;
// eop flag of the playing chunk
logic               eop_q;
logic               eop_nx;
// source of the next tick, head on a load, left otherwise
logic [chunk_w-1:0] src_cnt;
logic               src_eop;
logic [chunk_w-1:0] tick_cnt;
logic               load;
logic               advance;
logic [cnt_w-1:0]   num_nx;
logic               rd_eop_nx;

//////////////////////////////
// load decision
//////////////////////////////

// load when idle or when the tick on the outputs is the chunk's last
always_comb begin
        case (state)
        tick_pkg::st_idle:  load = 1'b1;
        // 23 words at most, so a third tick is always final
        tick_pkg::st_tick3: load = 1'b1;
        default:            load = (left == '0);
        endcase
end

// a tick goes out unless stalled or nothing is waiting
assign advance = rd_en && !(load && fifo_empty);

// pop only on a load that really happens
assign pop = advance && load;

//////////////////////////////
// next tick
//////////////////////////////

always_comb begin
        src_cnt   = load ? head.count : left;
        src_eop   = load ? head.eop : eop_q;
        // min of lanes and the words still to play
        tick_cnt  = (src_cnt > chunk_w'(lanes)) ? chunk_w'(lanes) : src_cnt;

        state_nx  = state;
        left_nx   = left;
        eop_nx    = eop_q;
        num_nx    = '0;
        rd_eop_nx = 1'b0;

        if (advance) begin
                num_nx    = cnt_w'(tick_cnt);
                left_nx   = src_cnt - tick_cnt;
                eop_nx    = src_eop;
                // eop rides on the tick that empties an EOP chunk
                rd_eop_nx = src_eop && (left_nx == '0);
                if (load) begin
                        state_nx = tick_pkg::st_tick1;
                end else if (state == tick_pkg::st_tick1) begin
                        state_nx = tick_pkg::st_tick2;
                end else begin
                        state_nx = tick_pkg::st_tick3;
                end
        end else if (rd_en) begin
                // last tick shown and the FIFO ran dry
                state_nx = tick_pkg::st_idle;
        end
        // rd_en low keeps everything and shows no words
end

always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
                state        <= tick_pkg::st_idle;
                left         <= '0;
                eop_q        <= 1'b0;
                rd_num_valid <= '0;
                rd_eop       <= 1'b0;
        end else begin
                state        <= state_nx;
                left         <= left_nx;
                eop_q        <= eop_nx;
                rd_num_valid <= num_nx;
                rd_eop       <= rd_eop_nx;
        end
end

endmodule

/* src/wide_read_scheduler.sv */
// wide read scheduler top that chains chunk builder, descriptor FIFO and tick scheduler
`include "sched_consts.svh"

module wide_read_scheduler (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [`SCHED_CNT_W-1:0] wr_num_valid,
        input  logic [`SCHED_CNT_W-1:0] wr_eop_position,
        input  logic                    rd_en,
        output logic [`SCHED_CNT_W-1:0] rd_num_valid,
        output logic                    rd_eop,
        output logic                    wr_overflow
);

// builder to FIFO
logic                   desc_push;
chunk_pkg::chunk_desc_t desc;
logic                   fifo_full;

// FIFO to scheduler
chunk_pkg::chunk_desc_t head;
logic                   fifo_empty;
logic                   pop;

//////////////////////////////
// write side
//////////////////////////////

chunk_builder chunk_builder_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_num_valid    (wr_num_valid),
        .wr_eop_position (wr_eop_position),
        .fifo_full       (fifo_full),
        .desc_push       (desc_push),
        .desc            (desc),
        .wr_overflow     (wr_overflow)
);

// descriptor buffer between the two clock-aligned sides
show_ahead_fifo #(
        .payload_t (chunk_pkg::chunk_desc_t),
        .depth     (`SCHED_FIFO_DEPTH)
) desc_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (desc_push),
        .wdata (desc),
        .pop   (pop),
        .rdata (head),
        .full  (fifo_full),
        .empty (fifo_empty)
);

//////////////////////////////
// read side
//////////////////////////////

tick_scheduler tick_scheduler_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .head         (head),
        .fifo_empty   (fifo_empty),
        .pop          (pop),
        .rd_num_valid (rd_num_valid),
        .rd_eop       (rd_eop)
);

endmodule

/* test/wide_read_scheduler_asserts.sv */
// assertion checker for the wide read scheduler top covering read ticks, pops, stalls and overflow
`include "sched_consts.svh"

module wide_read_scheduler_asserts (
        input logic                    clk,
        input logic                    rst_n,
        input logic                    rd_en,
        input logic [`SCHED_CNT_W-1:0] rd_num_valid,
        input logic                    rd_eop,
        input logic                    wr_overflow,
        input logic                    pop,
        input logic                    fifo_empty,
        input tick_pkg::tick_state_t   state
);

//////////////////////////////
// read side
//////////////////////////////

// one tick carries at most one lane group
ast_tick_max: assert property (@(posedge clk) disable iff (!rst_n)
        rd_num_valid <= `SCHED_LANES)
        else $error("read tick carries more words than there are lanes");

// the scheduler only pops a head that exists
ast_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && fifo_empty))
        else $error("descriptor popped from an empty FIFO");

// stalled cycle is followed by an empty tick
ast_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_en |=> rd_num_valid == '0)
        else $error("read tick shown after a cycle with rd_en low");

// only an EOP chunk of more than 16 words needs a third tick
// and that tick always closes the packet
ast_tick3_eop: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_num_valid != '0 && state == tick_pkg::st_tick3) |-> rd_eop)
        else $error("third tick of a chunk shown without rd_eop");

//////////////////////////////
// write side
//////////////////////////////

// overflow flag only clears through reset
ast_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        wr_overflow |=> wr_overflow)
        else $error("write overflow flag fell without a reset");

endmodule

// attach to every scheduler top
// the FSM state comes from inside the tick scheduler
bind wide_read_scheduler wide_read_scheduler_asserts wide_read_scheduler_asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .rd_num_valid (rd_num_valid),
        .rd_eop       (rd_eop),
        .wr_overflow  (wr_overflow),
        .pop          (pop),
        .fifo_empty   (fifo_empty),
        .state        (tick_scheduler_i.state)
);

/* test/wide_read_scheduler_tb.sv */
// testbench for the wide read scheduler with chunk reference model, tick monitor and directed tests
`include "sched_consts.svh"

module wide_read_scheduler_tb;

localparam int lanes = `SCHED_LANES;
localparam int half_period = 20;
localparam int drain_limit = 400;
localparam int flag_limit = 20;

logic                    clk;
logic                    rst_n;
logic [`SCHED_CNT_W-1:0] wr_num_valid;
logic [`SCHED_CNT_W-1:0] wr_eop_position;
logic                    rd_en;
logic [`SCHED_CNT_W-1:0] rd_num_valid;
logic                    rd_eop;
logic                    wr_overflow;

// expected ticks in play order
int    exp_cnt[$];
bit    exp_eop[$];
// model of the open chunk and of the FIFO room
// room of -1 means unlimited
int    pend;
int    room;
string test_name;
int    value_errors;
int    other_errors;
int    timeout_errors;
int    words_written;
int    words_expected;
int    words_read;
int    ticks_read;
int    eops_read;
logic  rd_en_prev;
logic [31:0] rng_state;
int    mon_cnt;
bit    mon_eop;

wide_read_scheduler wide_read_scheduler_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_num_valid    (wr_num_valid),
        .wr_eop_position (wr_eop_position),
        .rd_en           (rd_en),
        .rd_num_valid    (rd_num_valid),
        .rd_eop          (rd_eop),
        .wr_overflow     (wr_overflow)
);

initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
end

//////////////////////////////
// helpers
//////////////////////////////

function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
endfunction

task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
                $display("ERROR %s %s: expected %0d, actual %0d",
                         test_name, what, expected, actual);
                value_errors++;
        end
endtask

// split a chunk into ticks of 8 and a remainder
task automatic model_emit(input bit eop, input int count);
        int left;
        // full FIFO drops the whole descriptor
        if (room == 0) begin
                return;
        end
        if (room > 0) begin
                room--;
        end
        left = count;
        while (left > lanes) begin
                exp_cnt.push_back(lanes);
                exp_eop.push_back(1'b0);
                left -= lanes;
        end
        exp_cnt.push_back(left);
        exp_eop.push_back(eop);
        words_expected += count;
endtask

// chunk rule on one write cycle
task automatic model_write(input int num, input int eop_pos);
        if (eop_pos != 0) begin
                model_emit(1'b1, pend + eop_pos);
                pend = num - eop_pos;
        end else if (pend + num >= `SCHED_CHUNK_WORDS) begin
                model_emit(1'b0, `SCHED_CHUNK_WORDS);
                pend = pend + num - `SCHED_CHUNK_WORDS;
        end else begin
                pend = pend + num;
        end
endtask

task automatic drive_cycle(input int num, input int eop_pos, input bit en);
        @(negedge clk);
        wr_num_valid    = num;
        wr_eop_position = eop_pos;
        rd_en           = en;
        model_write(num, eop_pos);
        words_written += num;
endtask

task automatic reset_dut();
        @(negedge clk);
        rst_n           = 1'b0;
        wr_num_valid    = '0;
        wr_eop_position = '0;
        rd_en           = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        exp_cnt.delete();
        exp_eop.delete();
        pend           = 0;
        room           = -1;
        words_written  = 0;
        words_expected = 0;
        words_read     = 0;
        ticks_read     = 0;
        eops_read      = 0;
endtask

// read until every expected tick came out
// the queue only changes on falling edges
task automatic drain_reads();
        int waited;
        waited = 0;
        @(negedge clk);
        wr_num_valid    = '0;
        wr_eop_position = '0;
        rd_en           = 1'b1;
        @(posedge clk);
        while (exp_cnt.size() != 0 && waited < drain_limit) begin
                @(posedge clk);
                waited++;
        end
        assert (exp_cnt.size() == 0) else begin
                $display("timeout in %s: %0d expected ticks never came out",
                         test_name, exp_cnt.size());
                timeout_errors++;
                exp_cnt.delete();
                exp_eop.delete();
        end
        // room for stray ticks to show up
        repeat (4) @(negedge clk);
        @(posedge clk);
endtask

task automatic wait_overflow();
        int waited;
        waited = 0;
        while (!wr_overflow && waited < flag_limit) begin
                @(negedge clk);
                waited++;
        end
        assert (wr_overflow) else begin
                $display("timeout in %s: wr_overflow never rose", test_name);
                timeout_errors++;
        end
endtask

//////////////////////////////
// monitor
//////////////////////////////

always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
                rd_en_prev <= 1'b0;
        end else begin
                rd_en_prev <= rd_en;
        end
end

// outputs settle after the rising edge
// so they are looked at on the falling one
always @(negedge clk) begin
        if (rst_n && (rd_num_valid != '0 || rd_eop)) begin
                assert (rd_en_prev) else begin
                        $display("ERROR %s: a tick came out after a cycle with rd_en low",
                                 test_name);
                        other_errors++;
                end
                assert (exp_cnt.size() != 0) else begin
                        $display("ERROR %s: a tick came out with no tick expected", test_name);
                        other_errors++;
                end
                if (exp_cnt.size() != 0) begin
                        mon_cnt = exp_cnt.pop_front();
                        mon_eop = exp_eop.pop_front();
                        check_value("tick count", mon_cnt, rd_num_valid);
                        check_value("tick eop", mon_eop, rd_eop);
                end
                words_read += rd_num_valid;
                ticks_read++;
                if (rd_eop) begin
                        eops_read++;
                end
        end
end

//////////////////////////////
// directed tests
//////////////////////////////

task automatic test_full_chunks();
        test_name = "full_chunks";
        reset_dut();
        repeat (12) drive_cycle(lanes, 0, 1'b1);
        drain_reads();
        check_value("tick total", 12, ticks_read);
        check_value("words read", words_written, words_read);
endtask

task automatic test_eop_sizes();
        int n;
        int mode;
        int left;
        int k;
        int ticks0;
        int eops0;
        test_name = "eop_sizes";
        reset_dut();
        for (n = 1; n <= 23; n++) begin
                for (mode = 0; mode < 2; mode++) begin
                        ticks0 = ticks_read;
                        eops0  = eops_read;
                        if (mode == 0) begin
                                // whole lane groups from an empty chunk
                                left = n;
                                while (left > lanes) begin
                                        drive_cycle(lanes, 0, 1'b1);
                                        left -= lanes;
                                end
                                k = left;
                        end else begin
                                // open chunk filled up to 15 before the EOP cycle
                                k = (n > 15) ? n - 15 : 1;
                                left = n - k;
                                while (left > 0) begin
                                        drive_cycle((left > lanes) ? lanes : left, 0, 1'b1);
                                        left -= (left > lanes) ? lanes : left;
                                end
                        end
                        drive_cycle(k, k, 1'b1);
                        drain_reads();
                        check_value("ticks per packet", (n + lanes - 1) / lanes,
                                    ticks_read - ticks0);
                        check_value("eops per packet", 1, eops_read - eops0);
                end
        end
        check_value("words read", words_written, words_read);
endtask

task automatic test_back_to_back();
        test_name = "back_to_back";
        reset_dut();
        drive_cycle(1, 1, 1'b1);
        drive_cycle(1, 1, 1'b1);
        drive_cycle(1, 1, 1'b1);
        // EOP on the first word
        // two more words open the next packet
        drive_cycle(3, 1, 1'b1);
        drive_cycle(2, 2, 1'b1);
        drive_cycle(8, 3, 1'b1);
        drive_cycle(8, 8, 1'b1);
        drive_cycle(1, 1, 1'b1);
        drain_reads();
        check_value("packets read", 8, eops_read);
        check_value("words read", words_written, words_read);
endtask

task automatic test_back_pressure();
        test_name = "back_pressure";
        reset_dut();
        repeat (6) drive_cycle(lanes, 0, 1'b0);
        drive_cycle(5, 5, 1'b0);
        repeat (8) drive_cycle(0, 0, 1'b0);
        drain_reads();
        check_value("overflow flag", 0, wr_overflow);
        check_value("words read", words_written, words_read);
endtask

task automatic test_overflow();
        test_name = "overflow";
        reset_dut();
        room = `SCHED_FIFO_DEPTH;
        // twenty full chunks against a stalled reader
        repeat (40) drive_cycle(lanes, 0, 1'b0);
        wait_overflow();
        repeat (4) drive_cycle(0, 0, 1'b0);
        check_value("overflow flag", 1, wr_overflow);
        drain_reads();
        check_value("overflow flag after drain", 1, wr_overflow);
        check_value("words read", `SCHED_FIFO_DEPTH * `SCHED_CHUNK_WORDS, words_read);
        check_value("words modelled", words_expected, words_read);
endtask

task automatic test_random();
        int i;
        int num;
        int eop_pos;
        bit en;
        logic [31:0] r;
        test_name = "random";
        reset_dut();
        for (i = 0; i < 400; i++) begin
                rng_state = next_random(rng_state);
                r = rng_state;
                num = r % 9;
                eop_pos = 0;
                if (num > 0 && ((r >> 8) % 6) == 0) begin
                        eop_pos = 1 + (r >> 12) % num;
                end
                en = ((r >> 20) % 5) != 0;
                @(posedge clk);
                // hold the writer off while many ticks are still owed
                // so the FIFO stays below full
                if (exp_cnt.size() >= 12) begin
                        num = 0;
                        eop_pos = 0;
                end
                drive_cycle(num, eop_pos, en);
        end
        // close the open packet so every written word is read
        drive_cycle(1, 1, 1'b1);
        drain_reads();
        check_value("overflow flag", 0, wr_overflow);
        check_value("words read", words_written, words_read);
endtask

//////////////////////////////
// main sequence
//////////////////////////////

initial begin
        rst_n           = 1'b0;
        wr_num_valid    = '0;
        wr_eop_position = '0;
        rd_en           = 1'b0;
        rng_state       = 32'h4a4e17e8;
        value_errors    = 0;
        other_errors    = 0;
        timeout_errors  = 0;
        test_name       = "reset";
        reset_dut();
        test_full_chunks();
        test_eop_sizes();
        test_back_to_back();
        test_back_pressure();
        test_overflow();
        test_random();
        $display("errors: value %0d, other %0d, timeout %0d",
                 value_errors, other_errors, timeout_errors);
        if (value_errors + other_errors + timeout_errors == 0) begin
                $display("Result: PASSED");
        end else begin
                $display("Result: FAILED");
        end
        $finish;
end

endmodule

/* vlog.f */
+incdir+src
src/chunk_pkg.sv
src/tick_pkg.sv
src/show_ahead_fifo.sv
src/chunk_builder.sv
src/tick_scheduler.sv
src/wide_read_scheduler.sv
test/wide_read_scheduler_asserts.sv
test/wide_read_scheduler_tb.sv
